//--- Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_cnn_layer1
RTL_TOP   = cnn_layer1_top
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- bus_controller.sv
`default_nettype none
`timescale 1ns/100ps
`include "cnn_params.svh"

module bus_controller import cnn_pkg::*; (
	input  wire                  clk,
	input  wire                  rst,
	input  wire [31:0]           bus_addr,
	input  wire                  bus_write_signal,
	input  wire [31:0]           bus_write_data,
	input  wire                  busy,
	output logic                 awready,
	output logic                 write_pixel_mem,
	output logic                 write_weight_mem,
	output logic [`PIXEL_AW-1:0] mem_addr,
	output logic [`DATA_W-1:0]   mem_data,
	output logic [`ACC_W-1:0]    bias_value,
	output logic                 image_set_write,
	output logic                 irq_clear,
	output logic [1:0]           write_value,
	output logic                 pixel_store_done,
	output logic                 weight_store_done,
	output logic                 bias_store_done
);

	localparam int CNT_W = $clog2(`PIXEL_NUM + 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`PIXEL_NUM);

	bus_region_e      region;
	logic             accept;
	logic             wr_pixel;
	logic             wr_weight;
	logic             wr_bias;
	logic             wr_image_set;
	logic             wr_irq;
	logic [CNT_W-1:0] pixel_cnt;
	logic [CNT_W-1:0] weight_cnt;
	logic             bias_seen;

	// Writes are refused while the engine works on the stores
	assign awready = !busy;
	assign accept  = bus_write_signal && awready;
	assign region  = bus_region_e'(bus_addr[31:29]);

	assign wr_pixel     = accept && (region == R_PIXEL);
	assign wr_weight    = accept && (region == R_WEIGHT);
	assign wr_bias      = accept && (region == R_BIAS);
	assign wr_image_set = accept && (region == R_IMAGE_SET);
	assign wr_irq       = accept && (region == R_IRQ);

	// Routed strobes, one cycle after the bus pulse
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			write_pixel_mem  <= 1'b0;
			write_weight_mem <= 1'b0;
			image_set_write  <= 1'b0;
			irq_clear        <= 1'b0;
		end
		else
		begin
			write_pixel_mem  <= wr_pixel;
			write_weight_mem <= wr_weight;
			image_set_write  <= wr_image_set;
			irq_clear        <= wr_irq; // Any value clears
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			mem_addr    <= bus_addr[`PIXEL_AW-1:0];
			mem_data    <= bus_write_data[`DATA_W-1:0];
			write_value <= bus_write_data[1:0];
		end
		if (wr_bias)
			bias_value <= bus_write_data[`ACC_W-1:0];
	end

	// Store counters saturate, an interrupt clear starts a new image
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			pixel_cnt  <= '0;
			weight_cnt <= '0;
			bias_seen  <= 1'b0;
		end
		else if (wr_irq)
		begin
			pixel_cnt  <= '0;
			weight_cnt <= '0;
			bias_seen  <= 1'b0;
		end
		else
		begin
			if (wr_pixel && (pixel_cnt != CNT_FULL))
				pixel_cnt <= pixel_cnt + CNT_W'(1);
			if (wr_weight && (weight_cnt != CNT_FULL))
				weight_cnt <= weight_cnt + CNT_W'(1);
			if (wr_bias)
				bias_seen <= 1'b1;
		end
	end

	assign pixel_store_done  = (pixel_cnt == CNT_FULL);
	assign weight_store_done = (weight_cnt == CNT_FULL);
	assign bias_store_done   = bias_seen;

	// Memories stay frozen for the engine once it is busy
	a_no_write_in_busy: assert property (@(posedge clk) disable iff (rst)
		!(busy && (write_pixel_mem || write_weight_mem)))
		else $error("Local memory written during a compute");

endmodule

`default_nettype wire

//--- cnn_layer1_top.sv
`default_nettype none
`timescale 1ns/100ps
`include "cnn_params.svh"

module cnn_layer1_top import cnn_pkg::*; (
	input  wire         clk,
	input  wire         rst,
	input  wire [31:0]  bus_addr,
	input  wire         bus_write_signal,
	input  wire         bus_read_signal,
	input  wire [31:0]  bus_write_data,
	output logic [31:0] bus_read_data,
	output logic        awready,
	output logic        irq,
	output logic        pixel_store_done,
	output logic        weight_store_done,
	output logic        bias_store_done
);

	logic                 write_pixel_mem;
	logic                 write_weight_mem;
	logic [`PIXEL_AW-1:0] mem_addr;
	logic [`DATA_W-1:0]   mem_data;
	logic [`ACC_W-1:0]    bias_value;
	logic                 image_set_write;
	logic                 irq_clear;
	logic [1:0]           write_value;
	image_cmd_e           image_cmd;
	logic                 busy;
	logic                 done_pulse;
	logic [`ACC_W-1:0]    result;
	logic [`PIXEL_AW-1:0] rd_addr;     // Shared by both memories
	logic [`DATA_W-1:0]   pixel_rd_data;
	logic [`DATA_W-1:0]   weight_rd_data;

	bus_controller i_bus_controller (
		.clk(clk), .rst(rst), .bus_addr(bus_addr),
		.bus_write_signal(bus_write_signal), .bus_write_data(bus_write_data),
		.busy(busy), .awready(awready),
		.write_pixel_mem(write_pixel_mem), .write_weight_mem(write_weight_mem),
		.mem_addr(mem_addr), .mem_data(mem_data), .bias_value(bias_value),
		.image_set_write(image_set_write), .irq_clear(irq_clear),
		.write_value(write_value), .pixel_store_done(pixel_store_done),
		.weight_store_done(weight_store_done), .bias_store_done(bias_store_done)
	);

	local_mem #(.DEPTH(`PIXEL_NUM), .WIDTH(`DATA_W)) i_pixel_mem (
		.clk(clk), .wr_en(write_pixel_mem), .wr_addr(mem_addr),
		.wr_data(mem_data), .rd_addr(rd_addr), .rd_data(pixel_rd_data)
	);

	local_mem #(.DEPTH(`PIXEL_NUM), .WIDTH(`DATA_W)) i_weight_mem (
		.clk(clk), .wr_en(write_weight_mem), .wr_addr(mem_addr),
		.wr_data(mem_data), .rd_addr(rd_addr), .rd_data(weight_rd_data)
	);

	status_regs i_status_regs (
		.clk(clk), .rst(rst), .bus_addr(bus_addr), .bus_read_signal(bus_read_signal),
		.image_set_write(image_set_write), .irq_clear(irq_clear),
		.write_value(write_value), .done_pulse(done_pulse), .result(result),
		.image_cmd(image_cmd), .irq(irq), .bus_read_data(bus_read_data)
	);

	layer1_engine i_layer1_engine (
		.clk(clk), .rst(rst), .image_cmd(image_cmd),
		.pixel_store_done(pixel_store_done), .weight_store_done(weight_store_done),
		.bias_store_done(bias_store_done), .pixel_rd_data(pixel_rd_data),
		.weight_rd_data(weight_rd_data), .bias_value(bias_value),
		.rd_addr(rd_addr), .busy(busy), .done_pulse(done_pulse), .result(result)
	);

endmodule

`default_nettype wire

//--- cnn_params.svh
`ifndef CNN_PARAMS_SVH
`define CNN_PARAMS_SVH

// Pixels per image, also the weights per neuron
`define PIXEL_NUM 16

`define PIXEL_AW 13 // Local memory offset taken from bus_addr
`define DATA_W   16 // Signed pixel and weight
`define ACC_W    32 // Signed accumulator and result

// Region codes in bus_addr[31:29]
`define REG_PIXEL     3'b001
`define REG_WEIGHT    3'b010
`define REG_BIAS      3'b011
`define REG_IMAGE_SET 3'b100
`define REG_IRQ       3'b101
`define REG_RESULT    3'b110

`endif

//--- cnn_pkg.sv
`default_nettype none
`include "cnn_params.svh"

package cnn_pkg;

	// Every 3-bit code is named so a cast from the address is always legal
	typedef enum logic [2:0] {
		R_NONE      = 3'b000,
		R_PIXEL     = `REG_PIXEL,
		R_WEIGHT    = `REG_WEIGHT,
		R_BIAS      = `REG_BIAS,
		R_IMAGE_SET = `REG_IMAGE_SET,
		R_IRQ       = `REG_IRQ,
		R_RESULT    = `REG_RESULT,
		R_SPARE     = 3'b111
	} bus_region_e;

	typedef enum logic [1:0] {
		CMD_IDLE       = 2'b00,
		CMD_START      = 2'b01,
		CMD_START_RELU = 2'b11 // Start and clamp negatives
	} image_cmd_e;

	typedef enum logic [1:0] {
		E_IDLE  = 2'b00,
		E_RUN   = 2'b01, // Memory reads in flight
		E_DRAIN = 2'b10  // Pipe empties, bias and ReLU
	} engine_state_e;

endpackage

`default_nettype wire

//--- layer1_engine.sv
`default_nettype none
`timescale 1ns/100ps
`include "cnn_params.svh"

module layer1_engine import cnn_pkg::*; (
	input  wire                  clk,
	input  wire                  rst,
	input  var image_cmd_e       image_cmd,
	input  wire                  pixel_store_done,
	input  wire                  weight_store_done,
	input  wire                  bias_store_done,
	input  wire [`DATA_W-1:0]    pixel_rd_data,
	input  wire [`DATA_W-1:0]    weight_rd_data,
	input  wire [`ACC_W-1:0]     bias_value,
	output logic [`PIXEL_AW-1:0] rd_addr,
	output logic                 busy,
	output logic                 done_pulse,
	output logic [`ACC_W-1:0]    result
);

	localparam logic [`PIXEL_AW-1:0] LAST_ADDR = `PIXEL_AW'(`PIXEL_NUM - 1);

	engine_state_e                state;
	logic                         start;
	logic                         relu_q;
	logic                         rd_valid_q; // Memory data valid this cycle
	logic                         rd_last_q;
	logic                         fin_q;      // Accumulator holds the full sum
	logic signed [2*`DATA_W-1:0]  product;
	logic signed [`ACC_W-1:0]     acc;
	logic signed [`ACC_W-1:0]     sum;

	assign start = (state == E_IDLE) && (image_cmd != CMD_IDLE) &&
		pixel_store_done && weight_store_done && bias_store_done;

	assign busy = (state != E_IDLE) || start;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state   <= E_IDLE;
			rd_addr <= '0;
			relu_q  <= 1'b0;
		end
		else
		begin
			case (state)
				E_IDLE:
				begin
					if (start)
					begin
						state   <= E_RUN;
						rd_addr <= '0;
						relu_q  <= (image_cmd == CMD_START_RELU);
					end
				end
				E_RUN:
				begin
					if (rd_addr == LAST_ADDR)
						state <= E_DRAIN;
					else
						rd_addr <= rd_addr + `PIXEL_AW'(1);
				end
				E_DRAIN:
				begin
					if (done_pulse)
						state <= E_IDLE;
				end
				default: state <= E_IDLE;
			endcase
		end
	end

	// Valid pipe follows the registered memory read
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			rd_valid_q <= 1'b0;
			rd_last_q  <= 1'b0;
			fin_q      <= 1'b0;
			done_pulse <= 1'b0;
		end
		else
		begin
			rd_valid_q <= (state == E_RUN);
			rd_last_q  <= (state == E_RUN) && (rd_addr == LAST_ADDR);
			fin_q      <= rd_last_q;
			done_pulse <= fin_q;
		end
	end

	assign product = $signed(pixel_rd_data) * $signed(weight_rd_data);
	assign sum     = acc + $signed(bias_value);

	always_ff @(posedge clk)
	begin
		if (start)
			acc <= '0;
		else if (rd_valid_q)
			acc <= acc + `ACC_W'(product);
		if (fin_q)
			result <= (relu_q && sum[`ACC_W-1]) ? '0 : sum; // ReLU clamps negatives
	end

	a_done_one_cycle: assert property (@(posedge clk) disable iff (rst)
		done_pulse |=> !done_pulse)
		else $error("done_pulse held longer than one cycle");

endmodule

`default_nettype wire

//--- local_mem.sv
`default_nettype none
`timescale 1ns/100ps
`include "cnn_params.svh"

module local_mem #(
	parameter int DEPTH = `PIXEL_NUM,
	parameter int WIDTH = `DATA_W
) (
	input  wire                  clk,
	input  wire                  wr_en,
	input  wire [`PIXEL_AW-1:0]  wr_addr,
	input  wire [WIDTH-1:0]      wr_data,
	input  wire [`PIXEL_AW-1:0]  rd_addr,
	output logic [WIDTH-1:0]     rd_data
);

	localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam logic [`PIXEL_AW-1:0] DEPTH_A = `PIXEL_AW'(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge clk)
	begin
		if (wr_en && (wr_addr < DEPTH_A))
			mem[wr_addr[IDX_W-1:0]] <= wr_data;
	end

	// Registered read, out of range offsets read zero
	always_ff @(posedge clk)
	begin
		if (rd_addr < DEPTH_A)
			rd_data <= mem[rd_addr[IDX_W-1:0]];
		else
			rd_data <= '0;
	end

	a_wr_in_range: assert property (@(posedge clk) wr_en |-> (wr_addr < DEPTH_A))
		else $error("local_mem write offset %0d beyond depth %0d", wr_addr, DEPTH);

endmodule

`default_nettype wire

//--- status_regs.sv
`default_nettype none
`timescale 1ns/100ps
`include "cnn_params.svh"

module status_regs import cnn_pkg::*; (
	input  wire               clk,
	input  wire               rst,
	input  wire [31:0]        bus_addr,
	input  wire               bus_read_signal,
	input  wire               image_set_write,
	input  wire               irq_clear,
	input  wire [1:0]         write_value,
	input  wire               done_pulse,
	input  wire [`ACC_W-1:0]  result,
	output image_cmd_e        image_cmd,
	output logic              irq,
	output logic [31:0]       bus_read_data
);

	bus_region_e       rd_region;
	logic [`ACC_W-1:0] result_q;

	assign rd_region = bus_region_e'(bus_addr[31:29]);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			image_cmd <= CMD_IDLE;
			irq       <= 1'b0;
			result_q  <= '0;
		end
		else if (done_pulse)
		begin
			image_cmd <= CMD_IDLE; // Command clears itself when the neuron is done
			irq       <= 1'b1;
			result_q  <= result;
		end
		else
		begin
			if (image_set_write)
			begin
				case (write_value)
					2'b01:   image_cmd <= CMD_START;
					2'b11:   image_cmd <= CMD_START_RELU;
					default: image_cmd <= CMD_IDLE; // Code 10 is no command
				endcase
			end
			if (irq_clear)
				irq <= 1'b0;
		end
	end

	// Readback one cycle after the read strobe
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			bus_read_data <= '0;
		else if (bus_read_signal)
		begin
			case (rd_region)
				R_IMAGE_SET: bus_read_data <= {30'b0, image_cmd};
				R_IRQ:       bus_read_data <= {31'b0, irq};
				R_RESULT:    bus_read_data <= result_q;
				default:     bus_read_data <= '0;
			endcase
		end
	end

	// Clear comes from an accepted write, so never during a compute
	a_no_clear_on_done: assert property (@(posedge clk) disable iff (rst)
		!(done_pulse && irq_clear))
		else $error("irq_clear coincides with done_pulse");

endmodule

`default_nettype wire

//--- tb_cnn_layer1.sv
`default_nettype none
`timescale 1ns/100ps
`include "cnn_params.svh"

module tb_cnn_layer1 import cnn_pkg::*;;

	localparam int IRQ_TIMEOUT = 2 * `PIXEL_NUM + 16; // Cycles allowed for one neuron

	logic        clk;
	logic        rst;
	logic [31:0] bus_addr;
	logic        bus_write_signal;
	logic        bus_read_signal;
	logic [31:0] bus_write_data;
	logic [31:0] bus_read_data;
	logic        awready;
	logic        irq;
	logic        pixel_store_done;
	logic        weight_store_done;
	logic        bias_store_done;

	// Model of what the DUT should hold
	logic [`DATA_W-1:0] pix [`PIXEL_NUM];
	logic [`DATA_W-1:0] wgt [`PIXEL_NUM];
	logic [`ACC_W-1:0]  bias;
	image_cmd_e         cmd;

	logic [`ACC_W-1:0] got_q [$];
	logic [`ACC_W-1:0] exp_q [$];
	event              result_read;

	int    checks;
	int    errors;
	int    test_num;
	int    test_errs;
	string test_name;

	cnn_layer1_top i_cnn_layer1_top (
		.clk(clk), .rst(rst), .bus_addr(bus_addr),
		.bus_write_signal(bus_write_signal), .bus_read_signal(bus_read_signal),
		.bus_write_data(bus_write_data), .bus_read_data(bus_read_data),
		.awready(awready), .irq(irq), .pixel_store_done(pixel_store_done),
		.weight_store_done(weight_store_done), .bias_store_done(bias_store_done)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] region_addr(input bus_region_e r, input int off);
		region_addr = {r, 29'(off)};
	endfunction

	// Signed dot product plus bias, ReLU when asked
	function automatic logic [`ACC_W-1:0] expected_result(input image_cmd_e c);
		logic signed [`ACC_W-1:0]    sum;
		logic signed [2*`DATA_W-1:0] prod;
		sum = $signed(bias);
		for (int i = 0; i < `PIXEL_NUM; i++)
		begin
			prod = $signed(pix[i]) * $signed(wgt[i]);
			sum  = sum + `ACC_W'(prod);
		end
		if ((c == CMD_START_RELU) && (sum < 0))
			sum = '0;
		expected_result = sum;
	endfunction

	task automatic check_result(input string name, input logic [`ACC_W-1:0] got,
		input logic [`ACC_W-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_cmd(input string name, input image_cmd_e got, input image_cmd_e exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// Compares every value read back from the result region
	always @(result_read)
	begin
		while (got_q.size() > 0)
			check_result("result", got_q.pop_front(), exp_q.pop_front());
	end

	task automatic bus_write(input bus_region_e r, input int off, input logic [31:0] data);
		@(posedge clk);
		#1;
		bus_addr         = region_addr(r, off);
		bus_write_data   = data;
		bus_write_signal = 1'b1;
		@(posedge clk);
		#1;
		bus_write_signal = 1'b0;
	endtask

	task automatic bus_read(input bus_region_e r, output logic [31:0] data);
		@(posedge clk);
		#1;
		bus_addr        = region_addr(r, 0);
		bus_read_signal = 1'b1;
		@(posedge clk);
		#1;
		bus_read_signal = 1'b0;
		data            = bus_read_data; // Valid the cycle after the strobe
	endtask

	task automatic read_result(input logic [`ACC_W-1:0] exp, output logic [31:0] data);
		bus_read(R_RESULT, data);
		got_q.push_back(data);
		exp_q.push_back(exp);
		-> result_read;
	endtask

	task automatic wait_irq();
		int n;
		n = 0;
		while ((irq !== 1'b1) && (n < IRQ_TIMEOUT))
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (irq !== 1'b1)
		begin
			errors++;
			$display("Timeout after %0d cycles waiting for irq", IRQ_TIMEOUT);
		end
	endtask

	task automatic wait_awready_low();
		int n;
		n = 0;
		while ((awready !== 1'b0) && (n < 8))
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (awready !== 1'b0)
		begin
			errors++;
			$display("Timeout waiting for awready to drop at the compute start");
		end
	endtask

	task automatic store_pixels();
		for (int i = 0; i < `PIXEL_NUM; i++)
			bus_write(R_PIXEL, i, 32'(pix[i]));
	endtask

	task automatic store_weights();
		for (int i = 0; i < `PIXEL_NUM; i++)
			bus_write(R_WEIGHT, i, 32'(wgt[i]));
	endtask

	task automatic store_all();
		store_pixels();
		store_weights();
		bus_write(R_BIAS, 0, bias);
	endtask

	task automatic randomize_data();
		for (int i = 0; i < `PIXEL_NUM; i++)
		begin
			pix[i] = `DATA_W'($urandom);
			wgt[i] = `DATA_W'($urandom);
		end
		bias = $urandom;
	endtask

	task automatic start_cmd(input image_cmd_e c);
		cmd = c;
		bus_write(R_IMAGE_SET, 0, 32'(c));
	endtask

	task automatic new_image();
		bus_write(R_IRQ, 0, 32'h0);
		@(posedge clk); // irq register clears one cycle after the strobe
		#1;
	endtask

	task automatic begin_test(input string name);
		test_num++;
		test_name = name;
		test_errs = errors;
	endtask

	task automatic end_test();
		@(posedge clk);
		#1;
		if (errors == test_errs)
			$display("Test %0d %s: ok", test_num, test_name);
		else
			$display("Test %0d %s: %0d errors", test_num, test_name, errors - test_errs);
	endtask

	initial
	begin
		logic [31:0] d;
		logic        seen;
		clk              = 1'b0;
		rst              = 1'b1;
		bus_addr         = '0;
		bus_write_signal = 1'b0;
		bus_read_signal  = 1'b0;
		bus_write_data   = '0;
		bias             = '0;
		cmd              = CMD_IDLE;
		checks           = 0;
		errors           = 0;
		test_num         = 0;
		void'($urandom(32'h723a));
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		begin_test("reset state");
		check_bit("awready", awready, 1'b1);
		check_bit("irq", irq, 1'b0);
		check_bit("pixel_store_done", pixel_store_done, 1'b0);
		check_bit("weight_store_done", weight_store_done, 1'b0);
		check_bit("bias_store_done", bias_store_done, 1'b0);
		bus_read(R_IMAGE_SET, d);
		check_cmd("image_cmd", image_cmd_e'(d[1:0]), CMD_IDLE);
		read_result('0, d);
		end_test();

		begin_test("store counting");
		randomize_data();
		for (int i = 0; i < `PIXEL_NUM - 1; i++)
			bus_write(R_PIXEL, i, 32'(pix[i]));
		check_bit("pixel_store_done", pixel_store_done, 1'b0);
		bus_write(R_PIXEL, `PIXEL_NUM - 1, 32'(pix[`PIXEL_NUM - 1]));
		check_bit("pixel_store_done", pixel_store_done, 1'b1);
		for (int i = 0; i < `PIXEL_NUM - 1; i++)
			bus_write(R_WEIGHT, i, 32'(wgt[i]));
		check_bit("weight_store_done", weight_store_done, 1'b0);
		bus_write(R_WEIGHT, `PIXEL_NUM - 1, 32'(wgt[`PIXEL_NUM - 1]));
		check_bit("weight_store_done", weight_store_done, 1'b1);
		check_bit("bias_store_done", bias_store_done, 1'b0);
		bus_write(R_BIAS, 0, bias);
		check_bit("bias_store_done", bias_store_done, 1'b1);
		end_test();

		begin_test("linear compute");
		start_cmd(CMD_START);
		wait_irq();
		read_result(expected_result(CMD_START), d);
		bus_read(R_IMAGE_SET, d);
		check_cmd("image_cmd", image_cmd_e'(d[1:0]), CMD_IDLE);
		end_test();

		begin_test("relu compute");
		for (int i = 0; i < `PIXEL_NUM; i++)
		begin
			pix[i] = `DATA_W'(i + 1);
			wgt[i] = `DATA_W'(-(i + 3)); // Every product negative
		end
		bias = `ACC_W'(-5);
		new_image();
		store_all();
		start_cmd(CMD_START_RELU);
		wait_irq();
		read_result(expected_result(CMD_START_RELU), d);
		check_result("relu result", d, '0);
		new_image();
		store_all();
		start_cmd(CMD_START);
		wait_irq();
		read_result(expected_result(CMD_START), d);
		check_bit("result sign", d[`ACC_W-1], 1'b1);
		end_test();

		begin_test("gated start and back-pressure");
		new_image();
		randomize_data();
		store_pixels();
		store_weights();
		start_cmd(CMD_START);
		seen = 1'b0;
		for (int i = 0; i < `PIXEL_NUM + 8; i++)
		begin
			@(posedge clk);
			#1;
			seen = seen | irq;
		end
		check_bit("irq without bias", seen, 1'b0);
		bus_write(R_BIAS, 0, bias); // Completes the stores, compute starts
		wait_awready_low();
		check_bit("awready while busy", awready, 1'b0);
		// Both dropped by the controller, the engine reads these offsets last
		bus_write(R_PIXEL, `PIXEL_NUM - 1, 32'(~pix[`PIXEL_NUM - 1]));
		bus_write(R_PIXEL, `PIXEL_NUM - 2, 32'(~pix[`PIXEL_NUM - 2]));
		wait_irq();
		read_result(expected_result(CMD_START), d);
		end_test();

		begin_test("new image");
		new_image();
		check_bit("irq", irq, 1'b0);
		check_bit("pixel_store_done", pixel_store_done, 1'b0);
		check_bit("weight_store_done", weight_store_done, 1'b0);
		check_bit("bias_store_done", bias_store_done, 1'b0);
		for (int r = 0; r < 3; r++)
		begin
			new_image();
			randomize_data();
			store_all();
			start_cmd(($urandom & 1) ? CMD_START_RELU : CMD_START);
			wait_irq();
			read_result(expected_result(cmd), d);
		end
		end_test();

		$display("Tests %0d, checks %0d, errors %0d", test_num, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
cnn_pkg.sv
local_mem.sv
status_regs.sv
bus_controller.sv
layer1_engine.sv
cnn_layer1_top.sv
tb_cnn_layer1.sv
